/* design/mmu_ctrl_macros.svh */
/*
 * Sizes and register map of the matrix-multiply control unit.
 * Included by the package and by every module that needs a width or an offset.
 */

`ifndef MMU_CTRL_MACROS_SVH
`define MMU_CTRL_MACROS_SVH

// Processing array geometry
`define MMU_HEIGHT 4

// Counter widths
`define MMU_CNT_W   16
`define MMU_WCOMP_W 5

// Configuration bus
`define MMU_ADDR_W 4
`define MMU_DATA_W 32

// Word addresses on the configuration port
`define MMU_REG_TRIGGER 4'd0
`define MMU_REG_CLEAR   4'd1
`define MMU_REG_STATUS  4'd2
`define MMU_REG_W_ITERS 4'd3
`define MMU_REG_STORES  4'd4

`endif

/* design/mmu_ctrl_pkg.sv */
/*
 * Shared types of the control unit. Modules refer to them with
 * mmu_ctrl_pkg:: scoped names.
 */

`include "mmu_ctrl_macros.svh"

package mmu_ctrl_pkg;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_STARTING,
    PH_COMPUTING,
    PH_BUFFERING,
    PH_STORING,
    PH_FINISHED
  } ctrl_phase_e;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`MMU_ADDR_W-1:0] addr;
    logic [`MMU_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [`MMU_DATA_W-1:0] rdata;
    logic                   rvalid;
  } cfg_rsp_t;

  // Parameter word seen as a raw register or as a count in the upper half
  typedef union packed {
    logic [`MMU_DATA_W-1:0] raw;
    struct packed {
      logic [`MMU_CNT_W-1:0]             count;
      logic [`MMU_DATA_W-`MMU_CNT_W-1:0] rsvd;
    } fields;
  } param_word_u;

  typedef struct packed {
    logic [`MMU_CNT_W-1:0] w_rows_iter;
    logic [`MMU_CNT_W-1:0] tot_stores;
  } run_cfg_t;

  typedef struct packed {
    logic full;
    logic empty;
  } zbuf_flags_t;

  typedef struct packed {
    logic first_load;
    logic storing;
    logic finished;
    logic rst;
  } sched_ctrl_t;

  typedef struct packed {
    logic accum_set;
    logic reset_all;
  } tracker_cmd_t;

endpackage

/* design/mmu_cfg_regs.sv */
/*
 * Memory-mapped configuration port. Holds the two parameter words,
 * decodes the start and soft-clear triggers and answers reads one cycle
 * after the request with rvalid.
 */

`timescale 1ns/100ps

`include "mmu_ctrl_macros.svh"

module mmu_cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mmu_ctrl_pkg::cfg_req_t cfg_req_i,
  output mmu_ctrl_pkg::cfg_rsp_t cfg_rsp_o,
  input  logic                   busy_i,
  input  logic                   finish_i,
  output logic                   start_o,
  output logic                   clear_o,
  output mmu_ctrl_pkg::run_cfg_t run_cfg_o
);

  mmu_ctrl_pkg::param_word_u w_iters_q;
  mmu_ctrl_pkg::param_word_u stores_q;
  logic                      wr_en;
  logic                      rd_en;
  logic                      wr_clear;
  logic                      clear_q;
  logic                      done_q;
  logic                      rvalid_q;
  logic [`MMU_DATA_W-1:0]    rdata_d;
  logic [`MMU_DATA_W-1:0]    rdata_q;

  assign wr_en    = cfg_req_i.req & cfg_req_i.we;
  assign rd_en    = cfg_req_i.req & ~cfg_req_i.we;
  assign wr_clear = wr_en && (cfg_req_i.addr == `MMU_REG_CLEAR);

  // Start goes straight to the FSM so the run begins on the write edge
  assign start_o  = wr_en && (cfg_req_i.addr == `MMU_REG_TRIGGER);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_iters_q <= '0;
      stores_q  <= '0;
      clear_q   <= 1'b0;
      done_q    <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      if (wr_en && (cfg_req_i.addr == `MMU_REG_W_ITERS)) begin
        w_iters_q.raw <= cfg_req_i.wdata;
      end
      if (wr_en && (cfg_req_i.addr == `MMU_REG_STORES)) begin
        stores_q.raw <= cfg_req_i.wdata;
      end
      clear_q  <= wr_clear;
      rvalid_q <= rd_en;
      // Done stays up until the next run or a soft clear
      if (start_o || wr_clear) begin
        done_q <= 1'b0;
      end else if (finish_i) begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_req_i.addr)
      `MMU_REG_STATUS:  rdata_d = {{(`MMU_DATA_W-2){1'b0}}, done_q, busy_i};
      `MMU_REG_W_ITERS: rdata_d = w_iters_q.raw;
      `MMU_REG_STORES:  rdata_d = stores_q.raw;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.rdata  = rdata_q;
  assign cfg_rsp_o.rvalid = rvalid_q;
  assign clear_o          = clear_q;

  assign run_cfg_o.w_rows_iter = w_iters_q.fields.count;
  assign run_cfg_o.tot_stores  = stores_q.fields.count;

  a_rvalid_after_read : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_rsp_o.rvalid) |-> $past(rd_en)
  );

endmodule

/* design/mmu_weight_tracker.sv */
/*
 * Weight-row bookkeeping for the engine. Counts loaded rows and computed
 * weights, marks the last row and drives the accumulate level.
 * Reports to the controller when the last row has drained.
 */

`timescale 1ns/100ps

`include "mmu_ctrl_macros.svh"

module mmu_weight_tracker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       w_loaded_i,
  input  logic                       reg_enable_i,
  input  mmu_ctrl_pkg::ctrl_phase_e  phase_i,
  input  mmu_ctrl_pkg::tracker_cmd_t cmd_i,
  input  logic [`MMU_CNT_W-1:0]      w_rows_iter_i,
  output logic                       drain_done_o,
  output logic                       accumulate_o
);

  logic [`MMU_CNT_W-1:0]   row_q;
  logic [`MMU_CNT_W-1:0]   row_d;
  logic [`MMU_WCOMP_W-1:0] w_comp_q;
  logic                    armed_q;
  logic                    last_row_q;
  logic                    acc_q;
  logic                    in_comp;
  logic                    w_wrap;
  logic                    row_done;
  logic                    arm;
  logic                    last_set;
  logic                    flush_all;

  assign in_comp   = (phase_i == mmu_ctrl_pkg::PH_COMPUTING);
  assign flush_all = clear_i | cmd_i.reset_all;

  // Last row drains one weight earlier than a regular row completes
  assign drain_done_o = in_comp && last_row_q && reg_enable_i &&
                        (w_comp_q == `MMU_WCOMP_W'(`MMU_HEIGHT - 2));
  assign w_wrap   = in_comp && (w_comp_q == `MMU_WCOMP_W'(`MMU_HEIGHT - 1));
  assign row_done = w_wrap && !last_row_q;
  assign last_set = in_comp && (row_q >= w_rows_iter_i);
  assign arm      = in_comp && !armed_q &&
                    ((row_d >= `MMU_CNT_W'(`MMU_HEIGHT)) || last_set);

  always_comb begin
    row_d = row_q;
    if ((phase_i == mmu_ctrl_pkg::PH_IDLE) || cmd_i.reset_all) begin
      row_d = '0;
    end else if (drain_done_o) begin
      row_d = `MMU_CNT_W'(1);
    end else if (w_loaded_i) begin
      row_d = row_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q      <= '0;
      w_comp_q   <= '0;
      armed_q    <= 1'b0;
      last_row_q <= 1'b0;
      acc_q      <= 1'b0;
    end else begin
      row_q <= clear_i ? '0 : row_d;
      if (flush_all || w_wrap || drain_done_o) begin
        armed_q  <= 1'b0;
        w_comp_q <= '0;
      end else begin
        if (arm) begin
          armed_q <= 1'b1;
        end
        if (armed_q && reg_enable_i) begin
          w_comp_q <= w_comp_q + 1'b1;
        end
      end
      if (flush_all || (phase_i == mmu_ctrl_pkg::PH_BUFFERING)) begin
        last_row_q <= 1'b0;
      end else if (last_set) begin
        last_row_q <= 1'b1;
      end
      if (flush_all || drain_done_o) begin
        acc_q <= 1'b0;
      end else if (row_done || cmd_i.accum_set) begin
        acc_q <= 1'b1;
      end
    end
  end

  // Accumulate reaches the array only while it is enabled
  assign accumulate_o = acc_q & reg_enable_i;

  a_w_comp_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    w_comp_q < `MMU_WCOMP_W'(`MMU_HEIGHT)
  );

endmodule

/* design/mmu_store_counter.sv */
/*
 * Counts the completed store phases of a run and flags the last one.
 * Wraps to zero when the last store completes.
 */

`timescale 1ns/100ps

`include "mmu_ctrl_macros.svh"

module mmu_store_counter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  store_done_i,
  input  logic                  reset_all_i,
  input  logic [`MMU_CNT_W-1:0] tot_stores_i,
  output logic                  last_store_o
);

  logic [`MMU_CNT_W-1:0] cnt_q;
  logic [`MMU_CNT_W:0]   cur_num;

  // Number of the store in progress, one above the completed count
  assign cur_num = {1'b0, cnt_q} + 1'b1;

  // A zero total still runs a single store
  assign last_store_o = (cur_num >= {1'b0, tot_stores_i});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      if (clear_i || reset_all_i) begin
        cnt_q <= '0;
      end else if (store_done_i) begin
        cnt_q <= last_store_o ? '0 : cur_num[`MMU_CNT_W-1:0];
      end
    end
  end

  a_cnt_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= tot_stores_i
  );

endmodule

/* design/mmu_ctrl_fsm.sv */
/*
 * Six-phase run controller. The phase register moves once per cycle and
 * every engine and scheduler strobe is decoded from the current phase.
 */

`timescale 1ns/100ps

module mmu_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       test_mode_i,
  input  logic                       start_i,
  input  logic                       clear_i,
  input  logic                       w_loaded_i,
  input  logic                       reg_enable_i,
  input  mmu_ctrl_pkg::zbuf_flags_t  zbuf_flags_i,
  input  logic                       drain_done_i,
  input  logic                       last_store_i,
  output mmu_ctrl_pkg::ctrl_phase_e  phase_o,
  output mmu_ctrl_pkg::tracker_cmd_t trk_cmd_o,
  output logic                       store_done_o,
  output logic                       busy_o,
  output logic                       flush_o,
  output logic                       done_o,
  output logic                       w_shift_o,
  output logic                       z_fill_o,
  output logic                       z_buffer_clk_en_o,
  output mmu_ctrl_pkg::sched_ctrl_t  sched_ctrl_o
);

  mmu_ctrl_pkg::ctrl_phase_e phase_q;
  mmu_ctrl_pkg::ctrl_phase_e phase_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= mmu_ctrl_pkg::PH_IDLE;
    end else if (clear_i) begin
      phase_q <= mmu_ctrl_pkg::PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  always_comb begin
    phase_d           = phase_q;
    trk_cmd_o         = '0;
    sched_ctrl_o      = '0;
    store_done_o      = 1'b0;
    busy_o            = 1'b1;
    flush_o           = 1'b0;
    done_o            = 1'b0;
    w_shift_o         = 1'b1;
    z_fill_o          = 1'b0;
    z_buffer_clk_en_o = 1'b0;

    case (phase_q)
      mmu_ctrl_pkg::PH_IDLE: begin
        busy_o    = 1'b0;
        w_shift_o = 1'b0;
        // Soft clear also empties the output buffer
        z_buffer_clk_en_o = clear_i;
        if (start_i || test_mode_i) begin
          phase_d = mmu_ctrl_pkg::PH_STARTING;
        end
      end

      mmu_ctrl_pkg::PH_STARTING: begin
        w_shift_o               = 1'b0;
        sched_ctrl_o.first_load = 1'b1;
        if (w_loaded_i) begin
          phase_d = mmu_ctrl_pkg::PH_COMPUTING;
        end
      end

      mmu_ctrl_pkg::PH_COMPUTING: begin
        if (drain_done_i) begin
          phase_d = mmu_ctrl_pkg::PH_BUFFERING;
        end
      end

      mmu_ctrl_pkg::PH_BUFFERING: begin
        z_buffer_clk_en_o = 1'b1;
        z_fill_o          = reg_enable_i;
        // Next tile accumulates on top of the buffered one
        if (zbuf_flags_i.full) begin
          trk_cmd_o.accum_set = 1'b1;
          phase_d             = mmu_ctrl_pkg::PH_STORING;
        end
      end

      mmu_ctrl_pkg::PH_STORING: begin
        sched_ctrl_o.storing = 1'b1;
        if (zbuf_flags_i.empty) begin
          store_done_o = 1'b1;
          if (last_store_i) begin
            phase_d = mmu_ctrl_pkg::PH_FINISHED;
          end else begin
            phase_d = mmu_ctrl_pkg::PH_COMPUTING;
          end
        end
      end

      mmu_ctrl_pkg::PH_FINISHED: begin
        busy_o                = 1'b0;
        flush_o               = 1'b1;
        done_o                = 1'b1;
        sched_ctrl_o.finished = 1'b1;
        sched_ctrl_o.rst      = 1'b1;
        trk_cmd_o.reset_all   = 1'b1;
        phase_d               = mmu_ctrl_pkg::PH_IDLE;
      end

      default: begin
        phase_d = mmu_ctrl_pkg::PH_IDLE;
      end
    endcase
  end

  assign phase_o = phase_q;

  // A run ends with exactly one flush before going back to idle
  a_flush_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !flush_o
  );

endmodule

/* design/mmu_ctrl_top.sv */
/*
 * Control unit of the matrix-multiply engine. Connects the configuration
 * port, the phase controller, the weight tracker and the store counter.
 */

`timescale 1ns/100ps

module mmu_ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      test_mode_i,
  input  mmu_ctrl_pkg::cfg_req_t    cfg_req_i,
  output mmu_ctrl_pkg::cfg_rsp_t    cfg_rsp_o,
  input  logic                      w_loaded_i,
  input  logic                      reg_enable_i,
  input  mmu_ctrl_pkg::zbuf_flags_t zbuf_flags_i,
  output logic                      busy_o,
  output logic                      clear_o,
  output logic                      done_o,
  output logic                      flush_o,
  output logic                      accumulate_o,
  output logic                      w_shift_o,
  output logic                      z_fill_o,
  output logic                      z_buffer_clk_en_o,
  output mmu_ctrl_pkg::sched_ctrl_t sched_ctrl_o
);

  mmu_ctrl_pkg::run_cfg_t     run_cfg;
  mmu_ctrl_pkg::ctrl_phase_e  phase;
  mmu_ctrl_pkg::tracker_cmd_t trk_cmd;
  logic                       start;
  logic                       drain_done;
  logic                       store_done;
  logic                       last_store;

  mmu_cfg_regs i_cfg_regs (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .busy_i    ( busy_o    ),
    .finish_i  ( done_o    ),
    .start_o   ( start     ),
    .clear_o   ( clear_o   ),
    .run_cfg_o ( run_cfg   )
  );

  mmu_ctrl_fsm i_ctrl_fsm (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .test_mode_i       ( test_mode_i       ),
    .start_i           ( start             ),
    .clear_i           ( clear_o           ),
    .w_loaded_i        ( w_loaded_i        ),
    .reg_enable_i      ( reg_enable_i      ),
    .zbuf_flags_i      ( zbuf_flags_i      ),
    .drain_done_i      ( drain_done        ),
    .last_store_i      ( last_store        ),
    .phase_o           ( phase             ),
    .trk_cmd_o         ( trk_cmd           ),
    .store_done_o      ( store_done        ),
    .busy_o            ( busy_o            ),
    .flush_o           ( flush_o           ),
    .done_o            ( done_o            ),
    .w_shift_o         ( w_shift_o         ),
    .z_fill_o          ( z_fill_o          ),
    .z_buffer_clk_en_o ( z_buffer_clk_en_o ),
    .sched_ctrl_o      ( sched_ctrl_o      )
  );

  mmu_weight_tracker i_weight_tracker (
    .clk_i         ( clk_i               ),
    .rst_ni        ( rst_ni              ),
    .clear_i       ( clear_o             ),
    .w_loaded_i    ( w_loaded_i          ),
    .reg_enable_i  ( reg_enable_i        ),
    .phase_i       ( phase               ),
    .cmd_i         ( trk_cmd             ),
    .w_rows_iter_i ( run_cfg.w_rows_iter ),
    .drain_done_o  ( drain_done          ),
    .accumulate_o  ( accumulate_o        )
  );

  mmu_store_counter i_store_counter (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .clear_i      ( clear_o            ),
    .store_done_i ( store_done         ),
    .reset_all_i  ( trk_cmd.reset_all  ),
    .tot_stores_i ( run_cfg.tot_stores ),
    .last_store_o ( last_store         )
  );

endmodule

/* tests/tb_mmu_ctrl.sv */
/*
 * Testbench for the control unit. A random engine model answers the
 * controller, a monitor checks the strobes every cycle, and the main
 * sequence runs register, trigger, test-mode and soft-clear scenarios.
 */

`timescale 1ns/100ps

`include "mmu_ctrl_macros.svh"

module tb_mmu_ctrl;

  localparam int          RESET_CYC   = 16;
  localparam int          SHORT_WAIT  = 200;
  localparam int          RUN_TIMEOUT = 20000;
  localparam logic [31:0] SEED        = 32'h88cf_7320;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      test_mode_i;
  logic                      w_loaded_i;
  logic                      reg_enable_i;
  mmu_ctrl_pkg::cfg_req_t    cfg_req_i;
  mmu_ctrl_pkg::cfg_rsp_t    cfg_rsp_o;
  mmu_ctrl_pkg::zbuf_flags_t zbuf_flags_i;
  logic                      busy_o;
  logic                      clear_o;
  logic                      done_o;
  logic                      flush_o;
  logic                      accumulate_o;
  logic                      w_shift_o;
  logic                      z_fill_o;
  logic                      z_buffer_clk_en_o;
  mmu_ctrl_pkg::sched_ctrl_t sched_ctrl_o;

  // Event counts kept by the monitor, only ever incremented
  int unsigned store_rises;
  int unsigned flush_pulses;
  int unsigned done_pulses;
  int unsigned end_pulses;

  mmu_ctrl_top UUT (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .test_mode_i       ( test_mode_i       ),
    .cfg_req_i         ( cfg_req_i         ),
    .cfg_rsp_o         ( cfg_rsp_o         ),
    .w_loaded_i        ( w_loaded_i        ),
    .reg_enable_i      ( reg_enable_i      ),
    .zbuf_flags_i      ( zbuf_flags_i      ),
    .busy_o            ( busy_o            ),
    .clear_o           ( clear_o           ),
    .done_o            ( done_o            ),
    .flush_o           ( flush_o           ),
    .accumulate_o      ( accumulate_o      ),
    .w_shift_o         ( w_shift_o         ),
    .z_fill_o          ( z_fill_o          ),
    .z_buffer_clk_en_o ( z_buffer_clk_en_o ),
    .sched_ctrl_o      ( sched_ctrl_o      )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // Number of storing phases a run makes for a given total
  function automatic int unsigned expected_stores(input logic [15:0] tot);
    if (tot == 16'd0) begin
      return 1;
    end
    return 32'(tot);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: %s expected %0h actual %0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "simulation stopped on a mismatch");
    end
  endtask

  task automatic fail_wait(input string what);
    $display("timeout while waiting for %s", what);
    $display("test failed");
    $fatal(1, "simulation stopped on a timeout");
  endtask

  task automatic cfg_write(input logic [`MMU_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    cfg_req_i.req   = 1'b1;
    cfg_req_i.we    = 1'b1;
    cfg_req_i.addr  = addr;
    cfg_req_i.wdata = data;
    @(negedge clk_i);
    cfg_req_i = '0;
  endtask

  task automatic cfg_read(input logic [`MMU_ADDR_W-1:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    check_value("rvalid low before read", 32'h0, 32'(cfg_rsp_o.rvalid));
    cfg_req_i.req   = 1'b1;
    cfg_req_i.we    = 1'b0;
    cfg_req_i.addr  = addr;
    cfg_req_i.wdata = '0;
    @(negedge clk_i);
    check_value("rvalid one cycle after read", 32'h1, 32'(cfg_rsp_o.rvalid));
    data      = cfg_rsp_o.rdata;
    cfg_req_i = '0;
    @(negedge clk_i);
    check_value("rvalid single cycle", 32'h0, 32'(cfg_rsp_o.rvalid));
  endtask

  task automatic run_full(input string name, input logic [15:0] iters,
                          input logic [15:0] stores, input logic use_test_mode);
    int unsigned rises0;
    int unsigned flush0;
    int unsigned done0;
    int unsigned end0;
    int          cycles;
    logic [31:0] rd;
    cfg_write(`MMU_REG_W_ITERS, {iters, 16'h0});
    cfg_write(`MMU_REG_STORES, {stores, 16'h0});
    rises0 = store_rises;
    flush0 = flush_pulses;
    done0  = done_pulses;
    end0   = end_pulses;
    if (use_test_mode) begin
      test_mode_i = 1'b1;
      cycles      = 0;
      do begin
        @(negedge clk_i);
        cycles++;
      end while (!busy_o && cycles < SHORT_WAIT);
      if (!busy_o) begin
        fail_wait({name, " busy after test mode"});
      end
      test_mode_i = 1'b0;
    end else begin
      cfg_write(`MMU_REG_TRIGGER, 32'h0);
      check_value({name, " busy after trigger"}, 32'h1, 32'(busy_o));
    end
    check_value({name, " first_load at start"}, 32'h1, 32'(sched_ctrl_o.first_load));
    cycles = 0;
    while (done_pulses == done0 && cycles < RUN_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_pulses == done0) begin
      fail_wait({name, " done pulse"});
    end
    check_value({name, " busy after done"}, 32'h0, 32'(busy_o));
    // Let the unit sit in idle to catch stray pulses
    repeat (4) @(negedge clk_i);
    check_value({name, " busy stays low"}, 32'h0, 32'(busy_o));
    check_value({name, " storing phases"}, expected_stores(stores), store_rises - rises0);
    check_value({name, " flush pulses"}, 32'h1, flush_pulses - flush0);
    check_value({name, " done pulses"}, 32'h1, done_pulses - done0);
    check_value({name, " scheduler end pulses"}, 32'h1, end_pulses - end0);
    cfg_read(`MMU_REG_STATUS, rd);
    check_value({name, " status done"}, 32'h2, rd);
  endtask

  task automatic check_soft_clear();
    int          cycles;
    int unsigned done0;
    logic [31:0] rd;
    cfg_write(`MMU_REG_W_ITERS, {16'd8, 16'h0});
    cfg_write(`MMU_REG_STORES, {16'd4, 16'h0});
    done0 = done_pulses;
    cfg_write(`MMU_REG_TRIGGER, 32'h0);
    cycles = 0;
    while (sched_ctrl_o.first_load && cycles < SHORT_WAIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (sched_ctrl_o.first_load) begin
      fail_wait("first weight row before clear");
    end
    repeat (3) @(negedge clk_i);
    check_value("busy before clear", 32'h1, 32'(busy_o));
    cfg_write(`MMU_REG_CLEAR, 32'h0);
    check_value("clear pulse", 32'h1, 32'(clear_o));
    @(negedge clk_i);
    check_value("clear pulse width", 32'h0, 32'(clear_o));
    check_value("busy after clear", 32'h0, 32'(busy_o));
    cfg_read(`MMU_REG_STATUS, rd);
    check_value("status after clear", 32'h0, rd);
    check_value("no done on clear", done0, done_pulses);
    // A clear in idle also clocks the output buffer empty
    cfg_write(`MMU_REG_CLEAR, 32'h0);
    check_value("buffer clock on idle clear", 32'h1, 32'(z_buffer_clk_en_o));
  endtask

  // Engine model: random row loads and enables, buffer flags with a delay
  initial begin : engine_model
    int   full_wait;
    int   empty_wait;
    logic buf_seen;
    logic store_seen;
    void'($urandom(SEED));
    w_loaded_i   = 1'b0;
    reg_enable_i = 1'b0;
    zbuf_flags_i = '0;
    full_wait    = 0;
    empty_wait   = 0;
    buf_seen     = 1'b0;
    store_seen   = 1'b0;
    forever begin
      @(negedge clk_i);
      if (z_buffer_clk_en_o && busy_o) begin
        if (!buf_seen) begin
          buf_seen  = 1'b1;
          full_wait = 2 + int'($urandom % 5);
        end else if (full_wait > 1) begin
          full_wait--;
        end else begin
          zbuf_flags_i.full = 1'b1;
        end
      end else begin
        buf_seen          = 1'b0;
        zbuf_flags_i.full = 1'b0;
      end
      if (sched_ctrl_o.storing) begin
        if (!store_seen) begin
          store_seen = 1'b1;
          empty_wait = 2 + int'($urandom % 5);
        end else if (empty_wait > 1) begin
          empty_wait--;
        end else begin
          zbuf_flags_i.empty = 1'b1;
        end
      end else begin
        store_seen         = 1'b0;
        zbuf_flags_i.empty = 1'b0;
      end
      w_loaded_i   = ($urandom % 3) == 0;
      reg_enable_i = ($urandom % 4) != 0;
    end
  end

  // Cycle checks on the decoded strobes, sampled at the rising edge
  initial begin : monitor
    logic buffering;
    logic storing_q;
    logic flush_q;
    logic done_q;
    logic first_q;
    logic loaded_q;
    logic clear_q;
    store_rises  = 0;
    flush_pulses = 0;
    done_pulses  = 0;
    end_pulses   = 0;
    storing_q    = 1'b0;
    flush_q      = 1'b0;
    done_q       = 1'b0;
    first_q      = 1'b0;
    loaded_q     = 1'b0;
    clear_q      = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        buffering = z_buffer_clk_en_o & busy_o;
        check_value("z_fill follows reg_enable", 32'(buffering & reg_enable_i), 32'(z_fill_o));
        check_value("flush width", 32'h0, 32'(flush_q & flush_o));
        check_value("done width", 32'h0, 32'(done_q & done_o));
        // Accumulate is masked while the array is stalled
        if (!reg_enable_i) begin
          check_value("accumulate masked", 32'h0, 32'(accumulate_o));
        end
        // Buffer clock is off in starting and storing, and in idle unless cleared
        if (sched_ctrl_o.first_load || sched_ctrl_o.storing) begin
          check_value("z_buffer_clk_en off", 32'h0, 32'(z_buffer_clk_en_o));
        end else if (!busy_o && !done_o) begin
          check_value("z_buffer_clk_en in idle", 32'(clear_o), 32'(z_buffer_clk_en_o));
        end
        // First load holds until a row arrives, unless a clear ends the run
        if (first_q && !clear_q) begin
          check_value("first_load until load", 32'(!loaded_q), 32'(sched_ctrl_o.first_load));
        end
        if (sched_ctrl_o.storing && !storing_q) begin
          store_rises++;
        end
        if (flush_o) begin
          flush_pulses++;
        end
        if (done_o) begin
          done_pulses++;
        end
        if (sched_ctrl_o.finished && sched_ctrl_o.rst) begin
          end_pulses++;
        end
      end
      storing_q = sched_ctrl_o.storing;
      flush_q   = flush_o;
      done_q    = done_o;
      first_q   = sched_ctrl_o.first_load;
      loaded_q  = w_loaded_i;
      clear_q   = clear_o;
    end
  end

  initial begin : main_seq
    logic [31:0] rd;
    rst_ni      = 1'b0;
    test_mode_i = 1'b0;
    cfg_req_i   = '0;
    repeat (RESET_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("outputs after reset", 32'h0,
                32'({busy_o, clear_o, done_o, flush_o, accumulate_o, w_shift_o,
                     z_fill_o, sched_ctrl_o, cfg_rsp_o.rvalid}));

    cfg_read(`MMU_REG_STATUS, rd);
    check_value("status after reset", 32'h0, rd);
    cfg_write(`MMU_REG_W_ITERS, 32'h0005_c3a1);
    cfg_write(`MMU_REG_STORES, 32'h0002_7e19);
    cfg_read(`MMU_REG_W_ITERS, rd);
    check_value("w_iters readback", 32'h0005_c3a1, rd);
    cfg_read(`MMU_REG_STORES, rd);
    check_value("stores readback", 32'h0002_7e19, rd);

    run_full("trigger run", 16'd6, 16'd3, 1'b0);
    run_full("test mode run", 16'd3, 16'd0, 1'b1);
    run_full("single pass run", 16'd0, 16'd2, 1'b0);
    check_soft_clear();

    $display("test passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+design
design/mmu_ctrl_pkg.sv
design/mmu_cfg_regs.sv
design/mmu_weight_tracker.sv
design/mmu_store_counter.sv
design/mmu_ctrl_fsm.sv
design/mmu_ctrl_top.sv
tests/tb_mmu_ctrl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -f files.f --top-module tb_mmu_ctrl > build.log 2>&1 &&
./obj_dir/Vtb_mmu_ctrl > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation PASSED" || {
  cat build.log sim.log 2>/dev/null
  echo "simulation FAILED"
  exit 1
}
